// File: hw/axi_pkg.sv
////////////////////////////////////////
// bus protocol codes and field widths,
// imported by every AXI-style slave block
////////////////////////////////////////
`default_nettype none

package axi_pkg;

	// byte address and beat widths
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int strb_w = data_w / 8;

	// burst length field holds beats minus one
	localparam int len_w = 8;

	// arburst encodings
	typedef enum logic [1:0] {
		burst_fixed = 2'b00,
		burst_incr  = 2'b01,
		burst_wrap  = 2'b10
	} burst_t;

	// only okay and decerr are ever issued
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_decerr = 2'b11
	} resp_t;

endpackage

`default_nettype wire

// File: hw/mem_pkg.sv
////////////////////////////////////////
// storage geometry of the on-chip array
////////////////////////////////////////
`default_nettype none

package mem_pkg;

	// one word per beat
	localparam int word_bytes = 4;
	localparam int off_w      = $clog2(word_bytes);

	// array depth and word index width
	localparam int mem_words = 256;
	localparam int idx_w     = $clog2(mem_words);

	// first byte address past the array
	localparam int mem_bytes = mem_words * word_bytes;

endpackage

`default_nettype wire

// File: hw/rd_burst_fsm.sv
////////////////////////////////////////
// read channel FSM, takes AR and paces
// R beats under rready back-pressure
////////////////////////////////////////
`default_nettype none

module rd_burst_fsm import axi_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  arvalid,
	output logic  arready,
	input  logic  rready,
	output logic  rvalid,
	output logic  rlast,
	output resp_t rresp,
	output logic  ag_start,
	output logic  ag_step,
	output logic  fetch,
	input  logic  beat_ok,
	input  logic  beat_last,
	output logic  rd_idle
);

	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_fetch,
		st_send
	} state_t;

	state_t state;
	state_t state_nxt;
	logic   xfer;

	// beat leaves on this edge
	assign xfer = rvalid & rready;

	assign arready = (state == st_idle);
	assign rd_idle = (state == st_idle);
	assign rvalid  = (state == st_send);

	// generator latches araddr on the handshake
	assign ag_start = arready & arvalid;
	// last beat leaves the generator where it is
	assign ag_step  = xfer & ~rlast;
	// first fetch, then one per non-last transfer
	assign fetch    = (state == st_fetch) | ag_step;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:
				if (arvalid)
					state_nxt = st_load;
			st_load:
				state_nxt = st_fetch;
			st_fetch:
				state_nxt = st_send;
			st_send:
				if (xfer && rlast)
					state_nxt = st_idle;
			default:
				state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			rlast <= 1'b0;
		end else begin
			state <= state_nxt;
			// last flag tracks the beat being fetched
			if (fetch)
				rlast <= beat_last;
			else if (xfer)
				rlast <= 1'b0;
		end
	end

	// decerr for beats outside the array
	always_ff @(posedge clk) begin
		if (fetch)
			rresp <= beat_ok ? resp_okay : resp_decerr;
	end

	// stalled beat keeps its sideband
	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rlast) && $stable(rresp));

	a_rlast_valid: assert property (@(posedge clk) disable iff (rst)
		rlast |-> rvalid);

endmodule

`default_nettype wire

// File: hw/burst_addr_gen.sv
////////////////////////////////////////
// beat counter and address generator for
// FIXED, INCR and WRAP read bursts
////////////////////////////////////////
`default_nettype none

module burst_addr_gen import axi_pkg::*, mem_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic [addr_w-1:0] araddr,
	input  logic [len_w-1:0]  arlen,
	input  burst_t            arburst,
	input  logic              start,
	input  logic              step,
	input  logic              fetch,
	output logic [idx_w-1:0]  rd_idx,
	output logic              rd_en,
	output logic              beat_ok,
	output logic              beat_last
);

	logic [addr_w-1:0] cur_addr;
	logic [addr_w-1:0] inc_addr;
	logic [addr_w-1:0] wrap_mask;
	logic [addr_w-1:0] next_addr;
	logic [addr_w-1:0] pres_addr;
	logic [len_w-1:0]  len_q;
	logic [len_w-1:0]  cnt;
	logic [len_w-1:0]  pres_cnt;
	burst_t            burst_q;

	assign inc_addr  = cur_addr + addr_w'(word_bytes);
	// window is len+1 beats, aligned to its own size
	assign wrap_mask = ((addr_w'(len_q) + 1'b1) * addr_w'(word_bytes)) - 1'b1;

	always_comb begin
		case (burst_q)
			burst_incr: next_addr = inc_addr;
			burst_wrap: next_addr = (cur_addr & ~wrap_mask) | (inc_addr & wrap_mask);
			default:    next_addr = cur_addr;
		endcase
	end

	// on step the next beat is shown at once
	// so the array picks it up on the same edge
	assign pres_addr = step ? next_addr : cur_addr;
	assign pres_cnt  = step ? cnt + 1'b1 : cnt;

	assign rd_idx    = pres_addr[off_w +: idx_w];
	assign beat_ok   = (pres_addr < addr_w'(mem_bytes));
	assign beat_last = (pres_cnt == len_q);
	assign rd_en     = fetch & beat_ok;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt     <= '0;
			len_q   <= '0;
			burst_q <= burst_fixed;
		end else if (start) begin
			cnt     <= '0;
			len_q   <= arlen;
			burst_q <= arburst;
		end else if (step) begin
			cnt <= cnt + 1'b1;
		end
	end

	// current beat address
	always_ff @(posedge clk) begin
		if (start)
			cur_addr <= araddr;
		else if (step)
			cur_addr <= next_addr;
	end

	a_wrap_len: assert property (@(posedge clk) disable iff (rst)
		start && arburst == burst_wrap |-> arlen inside {8'd1, 8'd3, 8'd7, 8'd15});

	// read FSM never steps past the last beat
	a_step_range: assert property (@(posedge clk) disable iff (rst)
		step |-> cnt < len_q);

endmodule

`default_nettype wire

// File: hw/wr_ctrl.sv
////////////////////////////////////////
// single-beat write path that takes AW
// and W together and answers on B
////////////////////////////////////////
`default_nettype none

module wr_ctrl import axi_pkg::*, mem_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              awvalid,
	input  logic [addr_w-1:0] awaddr,
	input  logic              wvalid,
	input  logic [data_w-1:0] wdata,
	input  logic [strb_w-1:0] wstrb,
	output logic              awready,
	output logic              wready,
	output logic              bvalid,
	output resp_t             bresp,
	input  logic              bready,
	input  logic              rd_idle,
	input  logic              arvalid,
	output logic              wr_en,
	output logic [idx_w-1:0]  wr_idx,
	output logic [data_w-1:0] wr_data,
	output logic [strb_w-1:0] wr_strb
);

	typedef enum logic {
		st_idle,
		st_resp
	} state_t;

	state_t state;
	logic   take;
	logic   accept;
	logic   in_range;

	// pending read request wins a tie
	assign take     = (state == st_idle) & rd_idle & ~arvalid;
	assign awready  = take;
	assign wready   = take;
	assign accept   = take & awvalid & wvalid;
	assign in_range = (awaddr < addr_w'(mem_bytes));
	assign bvalid   = (state == st_resp);

	// array written on the accepting edge
	assign wr_en   = accept & in_range;
	assign wr_idx  = awaddr[off_w +: idx_w];
	assign wr_data = wdata;
	assign wr_strb = wstrb;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:
					if (accept)
						state <= st_resp;
				st_resp:
					if (bready)
						state <= st_idle;
				default:
					state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			bresp <= in_range ? resp_okay : resp_decerr;
	end

	// array port is never shared with a live burst
	a_wr_idle: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> rd_idle);

endmodule

`default_nettype wire

// File: hw/sram_array.sv
////////////////////////////////////////
// word array, registered read port and
// byte-strobed write port
////////////////////////////////////////
`default_nettype none

module sram_array import axi_pkg::*, mem_pkg::*; (
	input  logic              clk,
	input  logic              rd_en,
	input  logic              rd_zero,
	input  logic [idx_w-1:0]  rd_idx,
	output logic [data_w-1:0] rdata,
	input  logic              wr_en,
	input  logic [idx_w-1:0]  wr_idx,
	input  logic [data_w-1:0] wr_data,
	input  logic [strb_w-1:0] wr_strb
);

	logic [data_w-1:0] mem [mem_words];

	// power-up contents
	initial begin
		for (int i = 0; i < mem_words; i++)
			mem[i] = '0;
	end

	// only strobed bytes change
	always @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < strb_w; b++) begin
				if (wr_strb[b])
					mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
			end
		end
	end

	// out-of-range beat reads as zero
	always_ff @(posedge clk) begin
		if (rd_en)
			rdata <= mem[rd_idx];
		else if (rd_zero)
			rdata <= '0;
	end

endmodule

`default_nettype wire

// File: hw/axi_sram_top.sv
////////////////////////////////////////
// AXI-style SRAM slave, burst reads and
// single-beat strobed writes
////////////////////////////////////////
`default_nettype none

module axi_sram_top import axi_pkg::*, mem_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	// read address
	input  logic [addr_w-1:0] araddr,
	input  logic [len_w-1:0]  arlen,
	input  burst_t            arburst,
	input  logic              arvalid,
	output logic              arready,
	// read data
	output logic [data_w-1:0] rdata,
	output resp_t             rresp,
	output logic              rlast,
	output logic              rvalid,
	input  logic              rready,
	// write address and data
	input  logic              awvalid,
	input  logic [addr_w-1:0] awaddr,
	output logic              awready,
	input  logic              wvalid,
	input  logic [data_w-1:0] wdata,
	input  logic [strb_w-1:0] wstrb,
	output logic              wready,
	// write response
	output resp_t             bresp,
	output logic              bvalid,
	input  logic              bready
);

	logic              ag_start;
	logic              ag_step;
	logic              fetch;
	logic              beat_ok;
	logic              beat_last;
	logic              rd_idle;
	logic              rd_en;
	logic              rd_zero;
	logic [idx_w-1:0]  rd_idx;
	logic              wr_en;
	logic [idx_w-1:0]  wr_idx;
	logic [data_w-1:0] wr_data;
	logic [strb_w-1:0] wr_strb;

	// fetch of a beat outside the array
	assign rd_zero = fetch & ~beat_ok;

	rd_burst_fsm u_rd_burst_fsm (
		.clk       (clk),
		.rst       (rst),
		.arvalid   (arvalid),
		.arready   (arready),
		.rready    (rready),
		.rvalid    (rvalid),
		.rlast     (rlast),
		.rresp     (rresp),
		.ag_start  (ag_start),
		.ag_step   (ag_step),
		.fetch     (fetch),
		.beat_ok   (beat_ok),
		.beat_last (beat_last),
		.rd_idle   (rd_idle)
	);

	burst_addr_gen u_burst_addr_gen (
		.clk       (clk),
		.rst       (rst),
		.araddr    (araddr),
		.arlen     (arlen),
		.arburst   (arburst),
		.start     (ag_start),
		.step      (ag_step),
		.fetch     (fetch),
		.rd_idx    (rd_idx),
		.rd_en     (rd_en),
		.beat_ok   (beat_ok),
		.beat_last (beat_last)
	);

	wr_ctrl u_wr_ctrl (
		.clk     (clk),
		.rst     (rst),
		.awvalid (awvalid),
		.awaddr  (awaddr),
		.wvalid  (wvalid),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.awready (awready),
		.wready  (wready),
		.bvalid  (bvalid),
		.bresp   (bresp),
		.bready  (bready),
		.rd_idle (rd_idle),
		.arvalid (arvalid),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_data (wr_data),
		.wr_strb (wr_strb)
	);

	sram_array u_sram_array (
		.clk     (clk),
		.rd_en   (rd_en),
		.rd_zero (rd_zero),
		.rd_idx  (rd_idx),
		.rdata   (rdata),
		.wr_en   (wr_en),
		.wr_idx  (wr_idx),
		.wr_data (wr_data),
		.wr_strb (wr_strb)
	);

endmodule

`default_nettype wire

// File: verif/tb_axi_sram.sv
////////////////////////////////////////
// directed testbench for the SRAM slave
// with shadow memory and LFSR rready
////////////////////////////////////////
`default_nettype none

module tb_axi_sram import axi_pkg::*, mem_pkg::*; ();

	logic              clk;
	logic              rst;
	logic [addr_w-1:0] araddr;
	logic [len_w-1:0]  arlen;
	burst_t            arburst;
	logic              arvalid;
	logic              arready;
	logic [data_w-1:0] rdata;
	resp_t             rresp;
	logic              rlast;
	logic              rvalid;
	logic              rready;
	logic              awvalid;
	logic [addr_w-1:0] awaddr;
	logic              awready;
	logic              wvalid;
	logic [data_w-1:0] wdata;
	logic [strb_w-1:0] wstrb;
	logic              wready;
	resp_t             bresp;
	logic              bvalid;
	logic              bready;

	// expected array contents
	logic [data_w-1:0] shadow [mem_words];
	logic [7:0]        lfsr = 8'd85;
	int                cyc = 0;

	axi_sram_top u_axi_sram_top (
		.clk (clk), .rst (rst),
		.araddr (araddr), .arlen (arlen), .arburst (arburst),
		.arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rresp (rresp), .rlast (rlast),
		.rvalid (rvalid), .rready (rready),
		.awvalid (awvalid), .awaddr (awaddr), .awready (awready),
		.wvalid (wvalid), .wdata (wdata), .wstrb (wstrb), .wready (wready),
		.bresp (bresp), .bvalid (bvalid), .bready (bready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// cycle count read at negedge for beat timing
	always @(posedge clk)
		cyc <= cyc + 1;

	task automatic abort_run(string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
		if (exp !== act)
			abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	// 8-bit Fibonacci LFSR with taps 8 6 5 4
	function automatic logic next_rand_bit();
		logic fb;
		fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
		lfsr = {lfsr[6:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] fill_word(logic [31:0] addr);
		return (addr * 32'h0101_0101) ^ 32'hc3a5_5a3c;
	endfunction

	// byte address of beat i
	function automatic logic [31:0] beat_addr(logic [31:0] start, int len, burst_t burst, int i);
		logic [31:0] size;
		logic [31:0] base;
		size = (len + 1) * 4;
		base = start & ~(size - 1);
		case (burst)
			burst_incr: return start + 4 * i;
			burst_wrap: return base + ((start - base + 4 * i) % size);
			default:    return start;
		endcase
	endfunction

	task automatic write_word(string name, logic [31:0] addr, logic [31:0] data,
			logic [3:0] strb);
		int    waits;
		resp_t exp_resp;
		exp_resp = (addr < mem_bytes) ? resp_okay : resp_decerr;
		@(posedge clk);
		awaddr  <= addr;
		awvalid <= 1'b1;
		wdata   <= data;
		wstrb   <= strb;
		wvalid  <= 1'b1;
		bready  <= 1'b1;
		waits = 0;
		@(negedge clk);
		while (!(awready && wready)) begin
			waits++;
			if (waits > 50)
				abort_run({name, ": awready and wready never came high"});
			@(negedge clk);
		end
		// acceptance edge
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		waits = 0;
		@(negedge clk);
		while (!bvalid) begin
			waits++;
			if (waits > 50)
				abort_run({name, ": no write response on B"});
			@(negedge clk);
		end
		check_eq({name, " bresp"}, 32'(exp_resp), 32'(bresp));
		@(posedge clk);
		bready <= 1'b0;
		// strobe rule on the shadow for in-range words
		if (addr < mem_bytes) begin
			for (int b = 0; b < 4; b++)
				if (strb[b])
					shadow[addr >> 2][8*b +: 8] = data[8*b +: 8];
		end
	endtask

	task automatic read_burst(string name, logic [31:0] addr, int len, burst_t burst,
			bit rand_ready);
		int          waits;
		int          beat;
		int          ar_cyc;
		bit          stalled;
		logic [31:0] held;
		logic [31:0] ba;
		logic [31:0] exp_data;
		resp_t       exp_resp;
		@(posedge clk);
		araddr  <= addr;
		arlen   <= len_w'(len);
		arburst <= burst;
		arvalid <= 1'b1;
		waits = 0;
		@(negedge clk);
		while (!arready) begin
			waits++;
			if (waits > 50)
				abort_run({name, ": arready never came high"});
			@(negedge clk);
		end
		ar_cyc = cyc;
		@(posedge clk);
		arvalid <= 1'b0;
		beat    = 0;
		waits   = 0;
		stalled = 0;
		while (beat <= len) begin
			@(posedge clk);
			rready <= rand_ready ? next_rand_bit() : 1'b1;
			@(negedge clk);
			if (rvalid) begin
				// stalled beat must keep its data
				if (stalled)
					check_eq({name, " held rdata"}, held, rdata);
				if (rready) begin
					ba       = beat_addr(addr, len, burst, beat);
					exp_data = (ba < mem_bytes) ? shadow[ba >> 2] : '0;
					exp_resp = (ba < mem_bytes) ? resp_okay : resp_decerr;
					check_eq({name, " rdata"}, exp_data, rdata);
					check_eq({name, " rresp"}, 32'(exp_resp), 32'(rresp));
					check_eq({name, " rlast"}, 32'(beat == len), 32'(rlast));
					// two cycles of latency then one beat per cycle
					if (!rand_ready)
						check_eq({name, " beat cycle"}, ar_cyc + 3 + beat, cyc);
					beat++;
					waits   = 0;
					stalled = 0;
				end else begin
					stalled = 1;
					held    = rdata;
				end
			end
			waits++;
			if (waits > 100)
				abort_run({name, ": read beat never transferred"});
		end
		// final transfer edge
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic test_reset();
		@(negedge clk);
		check_eq("test_reset rvalid", 0, 32'(rvalid));
		check_eq("test_reset bvalid", 0, 32'(bvalid));
		check_eq("test_reset rlast", 0, 32'(rlast));
		check_eq("test_reset arready", 1, 32'(arready));
		check_eq("test_reset awready", 1, 32'(awready));
		check_eq("test_reset wready", 1, 32'(wready));
	endtask

	task automatic test_write_read();
		write_word("test_write_read", 32'h10, 32'h1122_3344, 4'b1111);
		write_word("test_write_read", 32'h14, 32'h5566_7788, 4'b1111);
		// partial strobes over earlier words
		write_word("test_write_read", 32'h10, 32'haabb_ccdd, 4'b0101);
		write_word("test_write_read", 32'h18, 32'hee00_0000, 4'b1000);
		for (int a = 32'h10; a <= 32'h18; a += 4)
			read_burst("test_write_read", a, 0, burst_incr, 0);
	endtask

	task automatic test_incr_burst();
		for (int i = 0; i < 8; i++)
			write_word("test_incr_burst", 32'h100 + 4 * i, fill_word(32'h100 + 4 * i), 4'hf);
		read_burst("test_incr_burst", 32'h100, 7, burst_incr, 0);
	endtask

	task automatic test_wrap_burst();
		for (int i = 0; i < 4; i++)
			write_word("test_wrap_burst", 32'h200 + 4 * i, fill_word(32'h200 + 4 * i), 4'hf);
		// 16-byte window entered at its third word
		read_burst("test_wrap_burst", 32'h208, 3, burst_wrap, 0);
	endtask

	task automatic test_backpressure();
		read_burst("test_backpressure fixed", 32'h104, 5, burst_fixed, 1);
		read_burst("test_backpressure incr", 32'h100, 7, burst_incr, 1);
	endtask

	task automatic test_decerr();
		write_word("test_decerr", 32'h3f8, fill_word(32'h3f8), 4'hf);
		write_word("test_decerr", 32'h3fc, fill_word(32'h3fc), 4'hf);
		// two beats inside and two past the end
		read_burst("test_decerr", 32'h3f8, 3, burst_incr, 0);
		write_word("test_decerr", mem_bytes, 32'hdead_beef, 4'hf);
		// word 0 is where a wrapped index would land
		read_burst("test_decerr", 32'h0, 0, burst_incr, 0);
	endtask

	initial begin
		for (int i = 0; i < mem_words; i++)
			shadow[i] = '0;
		rst     = 1'b1;
		araddr  = '0;
		arlen   = '0;
		arburst = burst_fixed;
		arvalid = 1'b0;
		rready  = 1'b0;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		bready  = 1'b0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		test_reset();
		test_write_read();
		test_incr_burst();
		test_wrap_burst();
		test_backpressure();
		test_decerr();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
hw/axi_pkg.sv
hw/mem_pkg.sv
hw/rd_burst_fsm.sv
hw/burst_addr_gen.sv
hw/wr_ctrl.sv
hw/sram_array.sv
hw/axi_sram_top.sv
verif/tb_axi_sram.sv
